/* hdl/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if import mips_ctrl_pkg::*; ();

	alu_op_e     alu_op;
	shift_op_e   shift_op;
	branch_op_e  branch_op;
	a_sel_e      a_sel;
	b_sel_e      b_sel;
	c_sel_e      c_sel;
	pc_sel_e     pc_sel;
	mem_op_e     mem_op;
	logic [15:0] imm;
	logic [25:0] jump_target;
	logic [4:0]  rd_index;

	modport dec (
		output alu_op, shift_op, branch_op, a_sel, b_sel, c_sel,
		output pc_sel, mem_op, imm, jump_target, rd_index
	);

	modport fetch (input pc_sel, branch_op, jump_target);

	modport exe (input alu_op, shift_op, a_sel, b_sel, c_sel, branch_op, imm, rd_index);

	modport mem (input mem_op);

endinterface

/* hdl/data_mem.sv */
`timescale 1ns/1ps

module data_mem import mips_ctrl_pkg::*; #(
	parameter int W = 32,
	parameter int L = 6
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic [N*W-1:0] data_mem_in_wire,
	input  logic [31:0]    addr,
	input  logic [31:0]    store_data,
	ctrl_if.mem            ctl,
	output logic [31:0]    load_data,
	output logic [N*W-1:0] data_mem_out_wire
);

	localparam int N = 2**L;

	logic [W-1:0] mem [N];
	logic [L-1:0] word_addr;

	assign word_addr = addr[L+1:2];
	assign load_data = 32'(mem[word_addr]);

	// preload from the input bus while reset is held
	always_ff @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < N; i++) begin
				mem[i] <= data_mem_in_wire[i*W +: W];
			end
		end else if (ctl.mem_op == MEM_STORE) begin
			mem[word_addr] <= W'(store_data);
		end
	end

	// whole array out flat, word 0 in the low bits
	always_comb begin
		for (int i = 0; i < N; i++) begin
			data_mem_out_wire[i*W +: W] = mem[i];
		end
	end

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder import mips_isa_pkg::*; import mips_ctrl_pkg::*; (
	input  logic [31:0] instruction,
	output logic [4:0]  rs_index,
	output logic [4:0]  rt_index,
	ctrl_if.dec         ctl
);

	opcode_e    opcode;
	funct_e     funct;
	logic [4:0] rt_field;
	logic [4:0] rd_field;

	assign opcode   = opcode_e'(instruction[OPCODE_MSB:OPCODE_LSB]);
	assign funct    = funct_e'(instruction[FUNCT_MSB:FUNCT_LSB]);
	assign rs_index = instruction[RS_MSB:RS_LSB];
	assign rt_field = instruction[RT_MSB:RT_LSB];
	assign rd_field = instruction[RD_MSB:RD_LSB];

	assign ctl.imm         = instruction[IMM_MSB:IMM_LSB];
	assign ctl.jump_target = instruction[TARGET_MSB:TARGET_LSB];

	always_comb begin
		// no-op unless the opcode says otherwise
		ctl.alu_op    = ALU_NONE;
		ctl.shift_op  = SHIFT_NONE;
		ctl.branch_op = BR_NONE;
		ctl.a_sel     = A_RS;
		ctl.b_sel     = B_RT;
		ctl.c_sel     = C_NONE;
		ctl.pc_sel    = PC_PLUS4;
		ctl.mem_op    = MEM_NONE;
		ctl.rd_index  = rt_field;
		rt_index      = rt_field;

		case (opcode)
			OP_SPECIAL: begin
				ctl.rd_index = rd_field;
				ctl.c_sel    = C_RESULT;
				case (funct)
					FN_ADDU: ctl.alu_op = ALU_ADD;
					FN_SUBU: ctl.alu_op = ALU_SUB;
					FN_AND:  ctl.alu_op = ALU_AND;
					FN_OR:   ctl.alu_op = ALU_OR;
					FN_XOR:  ctl.alu_op = ALU_XOR;
					FN_NOR:  ctl.alu_op = ALU_NOR;
					FN_SLT:  ctl.alu_op = ALU_SLT;
					FN_SLTU: ctl.alu_op = ALU_SLTU;
					FN_SLL: begin
						ctl.shift_op = SHIFT_SLL;
						ctl.a_sel    = A_SHAMT;
					end
					FN_SRL: begin
						ctl.shift_op = SHIFT_SRL;
						ctl.a_sel    = A_SHAMT;
					end
					FN_SRA: begin
						ctl.shift_op = SHIFT_SRA;
						ctl.a_sel    = A_SHAMT;
					end
					FN_SLLV: ctl.shift_op = SHIFT_SLL;
					FN_SRLV: ctl.shift_op = SHIFT_SRL;
					FN_JR: begin
						// rs | r0 puts the target on the result bus
						rt_index   = 5'd0;
						ctl.alu_op = ALU_OR;
						ctl.c_sel  = C_NONE;
						ctl.pc_sel = PC_REG;
					end
					default: ctl.c_sel = C_NONE;
				endcase
			end
			OP_ADDIU: begin
				ctl.alu_op = ALU_ADD;
				ctl.b_sel  = B_IMM_SIGN;
				ctl.c_sel  = C_RESULT;
			end
			OP_SLTI: begin
				ctl.alu_op = ALU_SLT;
				ctl.b_sel  = B_IMM_SIGN;
				ctl.c_sel  = C_RESULT;
			end
			// sign extended, then compared unsigned
			OP_SLTIU: begin
				ctl.alu_op = ALU_SLTU;
				ctl.b_sel  = B_IMM_SIGN;
				ctl.c_sel  = C_RESULT;
			end
			OP_ANDI: begin
				ctl.alu_op = ALU_AND;
				ctl.b_sel  = B_IMM_ZERO;
				ctl.c_sel  = C_RESULT;
			end
			OP_ORI: begin
				ctl.alu_op = ALU_OR;
				ctl.b_sel  = B_IMM_ZERO;
				ctl.c_sel  = C_RESULT;
			end
			OP_XORI: begin
				ctl.alu_op = ALU_XOR;
				ctl.b_sel  = B_IMM_ZERO;
				ctl.c_sel  = C_RESULT;
			end
			OP_LUI: begin
				ctl.alu_op = ALU_LUI;
				ctl.b_sel  = B_IMM_ZERO;
				ctl.c_sel  = C_RESULT;
			end
			OP_BEQ: begin
				ctl.branch_op = BR_EQ;
				ctl.pc_sel    = PC_BRANCH;
			end
			OP_BNE: begin
				ctl.branch_op = BR_NE;
				ctl.pc_sel    = PC_BRANCH;
			end
			OP_LW: begin
				ctl.alu_op = ALU_ADD;
				ctl.b_sel  = B_IMM_SIGN;
				ctl.c_sel  = C_MEMORY;
				ctl.mem_op = MEM_LOAD;
			end
			OP_SW: begin
				ctl.alu_op = ALU_ADD;
				ctl.b_sel  = B_IMM_SIGN;
				ctl.mem_op = MEM_STORE;
			end
			OP_J: ctl.pc_sel = PC_JUMP;
			OP_JAL: begin
				ctl.pc_sel   = PC_JUMP;
				ctl.c_sel    = C_PC_PLUS4;
				ctl.rd_index = LINK_REG;
			end
			default: ;
		endcase
	end

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import mips_ctrl_pkg::*; (
	ctrl_if.exe         ctl,
	input  logic [31:0] rs_value,
	input  logic [31:0] rt_value,
	input  logic [31:0] pc_plus4,
	input  logic [31:0] load_data,
	output logic [31:0] result,
	output logic        take_branch,
	output logic [31:0] store_data,
	output logic        wr_en,
	output logic [4:0]  wr_index,
	output logic [31:0] wr_data
);

	logic [31:0] a_bus;
	logic [31:0] b_bus;
	logic [31:0] c_alu;
	logic [31:0] c_shift;

	// ****************************************
	// operand muxes
	// ****************************************
	always_comb begin
		case (ctl.a_sel)
			// shamt is bits 10:6 of the low half
			A_SHAMT: a_bus = {27'd0, ctl.imm[10:6]};
			default: a_bus = rs_value;
		endcase
		case (ctl.b_sel)
			B_IMM_SIGN: b_bus = {{16{ctl.imm[15]}}, ctl.imm};
			B_IMM_ZERO: b_bus = {16'd0, ctl.imm};
			default:    b_bus = rt_value;
		endcase
	end

	// ****************************************
	// alu and shifter
	// ****************************************
	always_comb begin
		case (ctl.alu_op)
			ALU_ADD:  c_alu = a_bus + b_bus;
			ALU_SUB:  c_alu = a_bus - b_bus;
			ALU_AND:  c_alu = a_bus & b_bus;
			ALU_OR:   c_alu = a_bus | b_bus;
			ALU_XOR:  c_alu = a_bus ^ b_bus;
			ALU_NOR:  c_alu = ~(a_bus | b_bus);
			ALU_SLT:  c_alu = {31'd0, $signed(a_bus) < $signed(b_bus)};
			ALU_SLTU: c_alu = {31'd0, a_bus < b_bus};
			ALU_LUI:  c_alu = {b_bus[15:0], 16'd0};
			default:  c_alu = '0;
		endcase
	end

	// value comes from b, amount from a
	always_comb begin
		case (ctl.shift_op)
			SHIFT_SLL: c_shift = b_bus << a_bus[4:0];
			SHIFT_SRL: c_shift = b_bus >> a_bus[4:0];
			SHIFT_SRA: c_shift = $unsigned($signed(b_bus) >>> a_bus[4:0]);
			default:   c_shift = '0;
		endcase
	end

	// idle unit gives zero
	assign result = c_alu | c_shift;

	always_comb begin
		case (ctl.branch_op)
			BR_EQ:   take_branch = (rs_value == rt_value);
			BR_NE:   take_branch = (rs_value != rt_value);
			default: take_branch = 1'b0;
		endcase
	end

	// ****************************************
	// write back
	// ****************************************
	always_comb begin
		case (ctl.c_sel)
			C_MEMORY:   wr_data = load_data;
			C_PC_PLUS4: wr_data = pc_plus4;
			default:    wr_data = result;
		endcase
	end

	assign wr_en      = (ctl.c_sel != C_NONE);
	assign wr_index   = ctl.rd_index;
	assign store_data = rt_value;

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import mips_ctrl_pkg::*; #(
	parameter int W = 32,
	parameter int L = 6
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic [N*W-1:0] inst_mem_in_wire,
	input  logic           take_branch,
	input  logic [31:0]    reg_target,
	ctrl_if.fetch          ctl,
	output logic [31:0]    instruction,
	output logic [31:0]    pc_plus4
);

	localparam int N = 2**L;

	logic [31:0]  pc;
	logic [31:0]  pc_next;
	logic [31:0]  br_offset;
	logic         br_taken;
	logic [W-1:0] inst_word;

	// word select, pc is always word aligned
	assign inst_word   = inst_mem_in_wire[W*pc[L+1:2] +: W];
	assign instruction = 32'(inst_word);
	assign pc_plus4    = pc + 32'd4;

	// branch offset sits in the low half of the target field
	assign br_offset = {{14{ctl.jump_target[15]}}, ctl.jump_target[15:0], 2'b00};
	assign br_taken  = take_branch && (ctl.branch_op != BR_NONE);

	always_comb begin
		case (ctl.pc_sel)
			PC_BRANCH: pc_next = br_taken ? pc_plus4 + br_offset : pc_plus4;
			PC_JUMP:   pc_next = {pc_plus4[31:28], ctl.jump_target, 2'b00};
			PC_REG:    pc_next = {reg_target[31:2], 2'b00};
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

/* hdl/lite_mips.sv */
`timescale 1ns/1ps

module lite_mips #(
	parameter int W = 32,
	parameter int L = 6
) (
	input  logic           clk,
	input  logic           arst_n,
	input  logic [N*W-1:0] inst_mem_in_wire,
	input  logic [N*W-1:0] data_mem_in_wire,
	output logic [N*W-1:0] data_mem_out_wire
);

	localparam int N = 2**L;

	logic [31:0] instruction;
	logic [31:0] pc_plus4;
	logic [4:0]  rs_index;
	logic [4:0]  rt_index;
	logic [31:0] rs_value;
	logic [31:0] rt_value;
	logic [31:0] result;
	logic        take_branch;
	logic [31:0] store_data;
	logic        wr_en;
	logic [4:0]  wr_index;
	logic [31:0] wr_data;
	logic [31:0] load_data;

	ctrl_if ctl ();

	fetch_unit #(
		.W (W),
		.L (L)
	) u_fetch (
		.clk              (clk),
		.arst_n           (arst_n),
		.inst_mem_in_wire (inst_mem_in_wire),
		.take_branch      (take_branch),
		.reg_target       (result),
		.ctl              (ctl.fetch),
		.instruction      (instruction),
		.pc_plus4         (pc_plus4)
	);

	decoder u_decoder (
		.instruction (instruction),
		.rs_index    (rs_index),
		.rt_index    (rt_index),
		.ctl         (ctl.dec)
	);

	reg_bank u_reg_bank (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs_index (rs_index),
		.rt_index (rt_index),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_data  (wr_data),
		.rs_value (rs_value),
		.rt_value (rt_value)
	);

	execute_unit u_execute (
		.ctl         (ctl.exe),
		.rs_value    (rs_value),
		.rt_value    (rt_value),
		.pc_plus4    (pc_plus4),
		.load_data   (load_data),
		.result      (result),
		.take_branch (take_branch),
		.store_data  (store_data),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_data     (wr_data)
	);

	data_mem #(
		.W (W),
		.L (L)
	) u_data_mem (
		.clk               (clk),
		.arst_n            (arst_n),
		.data_mem_in_wire  (data_mem_in_wire),
		.addr              (result),
		.store_data        (store_data),
		.ctl               (ctl.mem),
		.load_data         (load_data),
		.data_mem_out_wire (data_mem_out_wire)
	);

endmodule

/* hdl/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	// ****************************************
	// execute unit functions
	// ****************************************
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [1:0] {
		SHIFT_SLL,
		SHIFT_SRL,
		SHIFT_SRA,
		SHIFT_NONE
	} shift_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE
	} branch_op_e;

	// ****************************************
	// bus selects
	// ****************************************
	typedef enum logic [1:0] {
		A_RS,
		A_SHAMT
	} a_sel_e;

	typedef enum logic [1:0] {
		B_RT,
		B_IMM_SIGN,
		B_IMM_ZERO
	} b_sel_e;

	// C_NONE means nothing is written back
	typedef enum logic [1:0] {
		C_RESULT,
		C_MEMORY,
		C_PC_PLUS4,
		C_NONE
	} c_sel_e;

	typedef enum logic [1:0] {
		PC_PLUS4,
		PC_BRANCH,
		PC_JUMP,
		PC_REG
	} pc_sel_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

endpackage

/* hdl/mips_isa_pkg.sv */
package mips_isa_pkg;

	// ****************************************
	// instruction field positions
	// ****************************************
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RS_MSB     = 25;
	localparam int RS_LSB     = 21;
	localparam int RT_MSB     = 20;
	localparam int RT_LSB     = 16;
	localparam int RD_MSB     = 15;
	localparam int RD_LSB     = 11;
	localparam int FUNCT_MSB  = 5;
	localparam int FUNCT_LSB  = 0;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;
	localparam int TARGET_MSB = 25;
	localparam int TARGET_LSB = 0;

	// jal writes the return address here
	localparam logic [4:0] LINK_REG = 5'd31;

	// ****************************************
	// primary opcodes
	// ****************************************
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field of SPECIAL
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_SLLV = 6'h04,
		FN_SRLV = 6'h06,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

endpackage

/* hdl/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [4:0]  rs_index,
	input  logic [4:0]  rt_index,
	input  logic        wr_en,
	input  logic [4:0]  wr_index,
	input  logic [31:0] wr_data,
	output logic [31:0] rs_value,
	output logic [31:0] rt_value
);

	// r0 has no storage
	logic [31:0] regs [31:1];

	assign rs_value = (rs_index == 5'd0) ? 32'd0 : regs[rs_index];
	assign rt_value = (rt_index == 5'd0) ? 32'd0 : regs[rt_index];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_index != 5'd0)) begin
			regs[wr_index] <= wr_data;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_lite_mips -f verilog.f

status=0
output=$(./obj_dir/Vtb_lite_mips 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, exit status $status"
exit 1

/* test/lite_mips_stim.txt */
# T cycles | I word_index instruction | D word_index data | E word_index expected | X end
# indices and words in hex, cycles in decimal, text after a hash is ignored
# arithmetic and logic on 0x12345678 and 0x0f0ff0f0
T 20
I 00 3c011234 # lui r1, 0x1234
I 01 34215678 # ori r1, r1, 0x5678
I 02 3c020f0f # lui r2, 0x0f0f
I 03 3442f0f0 # ori r2, r2, 0xf0f0
I 04 00221821 # addu r3, r1, r2
I 05 00222023 # subu r4, r1, r2
I 06 00222824 # and r5, r1, r2
I 07 00223025 # or r6, r1, r2
I 08 00223826 # xor r7, r1, r2
I 09 00224027 # nor r8, r1, r2
I 0a ac030000 # sw r3, 0(r0)
I 0b ac040004 # sw r4, 4(r0)
I 0c ac050008 # sw r5, 8(r0)
I 0d ac06000c # sw r6, 12(r0)
I 0e ac070010 # sw r7, 16(r0)
I 0f ac080014 # sw r8, 20(r0)
I 10 08000010 # j 0x40, halt
E 00 21444768
E 01 03246588
E 02 02045070
E 03 1f3ff6f8
E 04 1d3ba688
E 05 e0c00907
X
# signed and unsigned compares, immediate extension
T 18
I 00 2401fffb # addiu r1, r0, -5
I 01 24020003 # addiu r2, r0, 3
I 02 0022182a # slt r3, r1, r2
I 03 0022202b # sltu r4, r1, r2
I 04 2825fffc # slti r5, r1, -4
I 05 2c46ffff # sltiu r6, r2, -1
I 06 3027ff0f # andi r7, r1, 0xff0f
I 07 24288000 # addiu r8, r1, -0x8000
I 08 ac030000 # sw r3, 0(r0)
I 09 ac040004 # sw r4, 4(r0)
I 0a ac050008 # sw r5, 8(r0)
I 0b ac06000c # sw r6, 12(r0)
I 0c ac070010 # sw r7, 16(r0)
I 0d ac080014 # sw r8, 20(r0)
I 0e 0800000e # j 0x38, halt
D 01 deadbeef
E 00 00000001
E 01 00000000
E 02 00000001
E 03 00000001
E 04 0000ff0b
E 05 ffff7ffb
X
# shifts on a negative value
T 17
I 00 3c018765 # lui r1, 0x8765
I 01 34214321 # ori r1, r1, 0x4321
I 02 00011100 # sll r2, r1, 4
I 03 00011a02 # srl r3, r1, 8
I 04 00012203 # sra r4, r1, 8
I 05 2405000c # addiu r5, r0, 12
I 06 00a13004 # sllv r6, r1, r5
I 07 00a13806 # srlv r7, r1, r5
I 08 ac020000 # sw r2, 0(r0)
I 09 ac030004 # sw r3, 4(r0)
I 0a ac040008 # sw r4, 8(r0)
I 0b ac06000c # sw r6, 12(r0)
I 0c ac070010 # sw r7, 16(r0)
I 0d 0800000d # j 0x34, halt
E 00 76543210
E 01 00876543
E 02 ff876543
E 03 54321000
E 04 00087654
X
# load, modify, store; r0 stays zero
T 10
I 00 8c010040 # lw r1, 0x40(r0)
I 01 24220100 # addiu r2, r1, 0x100
I 02 ac020044 # sw r2, 0x44(r0)
I 03 24000055 # addiu r0, r0, 0x55
I 04 ac000048 # sw r0, 0x48(r0)
I 05 8c030044 # lw r3, 0x44(r0)
I 06 ac03004c # sw r3, 0x4c(r0)
I 07 08000007 # j 0x1c, halt
D 10 00001234
D 12 ffffffff
E 10 00001234
E 11 00001334
E 12 00000000
E 13 00001334
X
# loop to 5, branches both ways, jal and jr, halt
T 30
I 00 24010000 # addiu r1, r0, 0
I 01 24020005 # addiu r2, r0, 5
I 02 24210001 # addiu r1, r1, 1
I 03 1422fffe # bne r1, r2, -2
I 04 ac010000 # sw r1, 0(r0)
I 05 10220001 # beq r1, r2, +1 taken
I 06 ac000004 # sw r0, 4(r0) skipped
I 07 10200001 # beq r1, r0, +1 not taken
I 08 24030077 # addiu r3, r0, 0x77
I 09 0c00000e # jal 0x38
I 0a ac030008 # sw r3, 8(r0)
I 0b ac1f000c # sw r31, 12(r0)
I 0c 0800000c # j 0x30, halt
I 0d ac000010 # sw r0, 16(r0) never reached
I 0e 24630001 # addiu r3, r3, 1
I 0f 03e00008 # jr r31
D 01 11111111
D 04 22222222
E 00 00000005
E 01 11111111
E 02 00000078
E 03 00000028
E 04 22222222
X

/* test/tb_lite_mips.sv */
`timescale 1ns/1ps

module tb_lite_mips;

	localparam int W = 32;
	localparam int L = 6;
	localparam int N = 2**L;

	logic           clk;
	logic           arst_n;
	logic [N*W-1:0] inst_bus;
	logic [N*W-1:0] data_bus;
	logic [N*W-1:0] data_out;

	// stim records, each tagged with the test it belongs to
	int          test_cycles [$];
	logic [7:0]  rec_kind [$];
	int          rec_test [$];
	int          rec_addr [$];
	logic [31:0] rec_word [$];

	int cycle_count;
	int cycle_limit;
	int total_cycles;

	lite_mips #(
		.W (W),
		.L (L)
	) UUT (
		.clk               (clk),
		.arst_n            (arst_n),
		.inst_mem_in_wire  (inst_bus),
		.data_mem_in_wire  (data_bus),
		.data_mem_out_wire (data_out)
	);

	always #50 clk = ~clk;

	// ****************************************
	// reporting
	// ****************************************
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch at %0t: %s, expected %h, got %h",
				$time, what, expected, actual));
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			fail_run($sformatf("timeout, the run went past %0d clock cycles", cycle_limit));
		end
	end

	// ****************************************
	// stim file
	// ****************************************
	task automatic read_stim();
		int               fd;
		int               code;
		int               test_idx;
		int               value;
		int               addr;
		logic [7:0]       kind;
		logic [31:0]      word;
		logic [8*200-1:0] line_buf;
		fd = $fopen("test/lite_mips_stim.txt", "r");
		if (fd == 0) begin
			fail_run("could not open the stim file test/lite_mips_stim.txt");
		end
		test_idx = -1;
		while ($fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				// comment runs to the end of the line
				"#": code = $fgets(line_buf, fd);
				"T": begin
					code = $fscanf(fd, "%d", value);
					test_cycles.push_back(value);
					test_idx = test_idx + 1;
				end
				"I", "D", "E": begin
					code = $fscanf(fd, "%h %h", addr, word);
					if (code != 2 || test_idx < 0 || addr >= N) begin
						fail_run("bad memory record in the stim file");
					end
					rec_kind.push_back(kind);
					rec_test.push_back(test_idx);
					rec_addr.push_back(addr);
					rec_word.push_back(word);
				end
				"X": ;
				default: fail_run("unknown record type in the stim file");
			endcase
		end
		$fclose(fd);
	endtask

	// ****************************************
	// one test: load, reset, run, compare
	// ****************************************
	task automatic run_test(input int t);
		@(posedge clk);
		#10;
		arst_n   = 1'b0;
		inst_bus = '0;
		data_bus = '0;
		foreach (rec_kind[i]) begin
			if (rec_test[i] == t && rec_kind[i] == "I") begin
				inst_bus[rec_addr[i]*W +: W] = rec_word[i];
			end
			if (rec_test[i] == t && rec_kind[i] == "D") begin
				data_bus[rec_addr[i]*W +: W] = rec_word[i];
			end
		end
		// data memory takes its preload on these edges
		repeat (2) @(posedge clk);
		#10;
		arst_n = 1'b1;
		repeat (test_cycles[t]) @(posedge clk);
		#10;
		foreach (rec_kind[i]) begin
			if (rec_test[i] == t && rec_kind[i] == "E") begin
				check_value(data_out[rec_addr[i]*W +: W], rec_word[i],
					$sformatf("test %0d data word %0d", t, rec_addr[i]));
			end
		end
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b1;
		inst_bus     = '0;
		data_bus     = '0;
		cycle_count  = 0;
		cycle_limit  = 0;
		total_cycles = 0;
		read_stim();
		foreach (test_cycles[t]) begin
			total_cycles = total_cycles + test_cycles[t];
		end
		cycle_limit = total_cycles + 20 * test_cycles.size();
		for (int t = 0; t < test_cycles.size(); t++) begin
			run_test(t);
		end
		if (test_cycles.size() == 0) begin
			fail_run("the stim file holds no tests");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* verilog.f */
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/ctrl_if.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_bank.sv
hdl/execute_unit.sv
hdl/data_mem.sv
hdl/lite_mips.sv
test/tb_lite_mips.sv
